// ==== bench/tb_vex_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module tb_vex_execute;

  localparam int N_ALU = 40;
  localparam int N_RED = 16;
  localparam int N_MEM = 24;
  localparam int N_STREAM = 80;
  localparam int N_AFTER_FLUSH = 12;
  localparam int OPS_TOTAL = 3 * N_ALU + 2 * N_RED + 2 * N_MEM + N_STREAM + N_AFTER_FLUSH + 2;
  // 200 ns per op plus room for reset and the APB accesses
  localparam int WATCHDOG_NS = OPS_TOTAL * 200 + 50000;

  logic CLK = 1'b0;
  logic nRST;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [`VEX_XLEN-1:0] pwdata;
  logic [`VEX_XLEN-1:0] prdata;
  logic pready;
  logic pslverr;
  logic op_valid;
  vex_pkg::vex_op_t op;
  logic op_ready;
  logic res_valid;
  vex_pkg::vex_res_t res;
  logic mem_ready;
  logic flush;

  // config as the testbench expects it to be
  logic [`VEX_VL_W-1:0] m_vl = `VEX_VL_W'(0);
  vex_pkg::sew_e m_sew = vex_pkg::SEW32;
  logic [`VEX_XLEN-1:0] m_stride = 32'd4;
  logic apb_exp_err = 1'b0;
  logic [`VEX_XLEN-1:0] apb_exp_rd = '0;

  vex_pkg::vex_res_t exp_q[$];
  vex_pkg::vex_res_t exp_head = '0;
  int exp_count = 0;
  int acc_cycles = 0;
  int errors = 0;
  int mem_mode = 0;
  logic [31:0] rng = 32'd20;

  vex_execute u_vex_execute (.CLK, .nRST, .psel, .penable, .pwrite, .paddr, .pwdata,
                             .prdata, .pready, .pslverr, .op_valid, .op, .op_ready,
                             .res_valid, .res, .mem_ready, .flush);

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] pick(input vex_pkg::src_e s, input logic [31:0] v,
                                       input logic [31:0] imm, input logic [31:0] xs);
    if (s == vex_pkg::SRC_V) return v;
    if (s == vex_pkg::SRC_I) return imm;
    return xs;
  endfunction

  // signed less-than on the low sew bits
  function automatic logic signed_lt(input logic [31:0] a, input logic [31:0] b,
                                     input vex_pkg::sew_e sew);
    case (sew)
      vex_pkg::SEW8:  return $signed(a[7:0]) < $signed(b[7:0]);
      vex_pkg::SEW16: return $signed(a[15:0]) < $signed(b[15:0]);
      default:        return $signed(a) < $signed(b);
    endcase
  endfunction

  function automatic logic [31:0] ref_alu(input vex_pkg::alu_op_e f, input logic [31:0] a,
                                          input logic [31:0] b, input vex_pkg::sew_e sew);
    case (f)
      vex_pkg::ALU_ADD:  return a + b;
      vex_pkg::ALU_AND:  return a & b;
      vex_pkg::ALU_OR:   return a | b;
      vex_pkg::ALU_XOR:  return a ^ b;
      vex_pkg::ALU_MIN:  return signed_lt(a, b, sew) ? a : b;
      vex_pkg::ALU_MINU: return (a < b) ? a : b;
      vex_pkg::ALU_MAX:  return signed_lt(a, b, sew) ? b : a;
      default:           return (a < b) ? b : a;
    endcase
  endfunction

  function automatic vex_pkg::vex_res_t model(input vex_pkg::vex_op_t o);
    vex_pkg::vex_res_t r;
    logic [31:0] l0;
    logic [31:0] l1;
    logic [31:0] esize;
    logic [31:0] lstride;
    r = '0;
    r.fu = o.fu;
    r.vd = o.vd;
    r.wen = o.wen;
    r.store0 = o.store0;
    r.store1 = o.store1;
    if (o.fu == vex_pkg::FU_LOAD || o.fu == vex_pkg::FU_STORE) begin
      esize = (o.eew == vex_pkg::SEW8) ? 1 : (o.eew == vex_pkg::SEW16) ? 2 : 4;
      case (o.stride_type)
        vex_pkg::STRIDE_UNIT:    lstride = 4;
        vex_pkg::STRIDE_STRIDED: lstride = m_stride;
        default:                 lstride = (o.nf + 1) * esize;
      endcase
      r.result0 = o.xs2 + o.nf_count * esize;
      r.result1 = r.result0 + lstride;
    end else begin
      l0 = ref_alu(o.alu_op, pick(o.src1, o.vs1_lane0, o.imm, o.xs1),
                   pick(o.src2, o.vs2_lane0, o.imm, o.xs1), m_sew);
      l1 = ref_alu(o.alu_op, pick(o.src1, o.vs1_lane1, o.imm, o.xs1),
                   pick(o.src2, o.vs2_lane1, o.imm, o.xs1), m_sew);
      r.result0 = (o.reduce && m_vl != 1) ? ref_alu(o.alu_op, l0, l1, m_sew) : l0;
      r.result1 = l1;
    end
    return r;
  endfunction

  // kind 0 is ALU, 1 is load or store, 2 is any
  function automatic vex_pkg::vex_op_t make_op(input int kind, input logic red);
    vex_pkg::vex_op_t o;
    logic [31:0] r;
    r = rand32();
    o.fu = (kind == 0) ? vex_pkg::FU_ALU : (kind == 1) ? vex_pkg::fu_e'(2'(1 + r[0])) :
           vex_pkg::fu_e'(2'(r % 3));
    o.alu_op = vex_pkg::alu_op_e'(r[6:4]);
    o.src1 = vex_pkg::src_e'(2'(r[15:8] % 3));
    o.src2 = vex_pkg::src_e'(2'(r[23:16] % 3));
    o.reduce = red;
    o.eew = vex_pkg::sew_e'(2'(r[31:24] % 3));
    o.stride_type = vex_pkg::stride_e'(2'(r[11:9] % 3));
    o.nf = r[27:25];
    o.nf_count = r[30:28];
    o.vd = r[21:17];
    o.wen = r[3:2];
    o.imm = rand32();
    o.xs1 = rand32();
    o.xs2 = rand32();
    o.vs1_lane0 = rand32();
    o.vs1_lane1 = rand32();
    o.vs2_lane0 = rand32();
    o.vs2_lane1 = rand32();
    o.store0 = rand32();
    o.store1 = rand32();
    return o;
  endfunction

  function automatic logic [31:0] cfg_readback(input logic [7:0] addr);
    case (addr)
      `VEX_CFG_VL:     return 32'(m_vl);
      `VEX_CFG_VTYPE:  return 32'(m_sew);
      `VEX_CFG_STRIDE: return m_stride;
      default:         return '0;
    endcase
  endfunction

  // one APB transfer starting on a falling edge
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    logic mapped;
    mapped = addr == `VEX_CFG_VL || addr == `VEX_CFG_VTYPE || addr == `VEX_CFG_STRIDE;
    apb_exp_err = !mapped || (wr && addr == `VEX_CFG_VL && data > `VEX_VLMAX);
    apb_exp_rd = cfg_readback(addr);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    @(negedge CLK);
    penable = 1'b1;
    @(negedge CLK);
    psel = 1'b0;
    penable = 1'b0;
    if (wr && !apb_exp_err) begin
      if (addr == `VEX_CFG_VL) m_vl = data[`VEX_VL_W-1:0];
      if (addr == `VEX_CFG_VTYPE) m_sew = vex_pkg::sew_e'(data[1:0]);
      if (addr == `VEX_CFG_STRIDE) m_stride = data;
    end
  endtask

  task automatic write_read(input logic [7:0] addr, input logic [31:0] data);
    apb_access(1'b1, addr, data);
    apb_access(1'b0, addr, 32'd0);
  endtask

  task automatic set_mem_ready();
    logic [31:0] r;
    r = rand32();
    mem_ready = (mem_mode == 0) ? 1'b1 : (mem_mode == 1) ? r[0] : 1'b0;
  endtask

  // holds op_valid until the op is taken and returns on the next falling edge
  task automatic send_op(input vex_pkg::vex_op_t o);
    logic taken;
    op_valid = 1'b1;
    op = o;
    set_mem_ready();
    taken = 1'b0;
    while (!taken) begin
      @(posedge CLK);
      taken = op_ready && !flush;
      @(negedge CLK);
      if (!taken) set_mem_ready();
    end
  endtask

  task automatic run_ops(input int n, input int kind, input logic red);
    int i;
    for (i = 0; i < n; i++) send_op(make_op(kind, red));
  endtask

  task automatic drain();
    op_valid = 1'b0;
    mem_mode = 0;
    mem_ready = 1'b1;
    while (exp_count != 0) @(negedge CLK);
    @(negedge CLK);
  endtask

  // expected results in accept order
  always @(posedge CLK) begin
    if (!nRST || flush) begin
      exp_q.delete();
    end else begin
      if (res_valid && mem_ready && exp_q.size() != 0) void'(exp_q.pop_front());
      if (op_valid && op_ready) exp_q.push_back(model(op));
    end
    if (nRST && acc_cycles < 2 && (acc_cycles != 0 || (op_valid && op_ready && !flush)))
      acc_cycles++;
    exp_count = exp_q.size();
    exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
  end

  a_res_match: assert property (@(posedge CLK) disable iff (!nRST)
    (res_valid && mem_ready && exp_count != 0) |-> (res == exp_head))
    else begin
      errors++;
      $display("[FAIL] %0d ns res expected %h got %h", $time, $sampled(exp_head),
               $sampled(res));
    end

  a_no_extra: assert property (@(posedge CLK) disable iff (!nRST)
    res_valid |-> (exp_count != 0))
    else begin
      errors++;
      $display("%0d ns: result valid with no op outstanding", $time);
    end

  a_held: assert property (@(posedge CLK) disable iff (!nRST)
    (res_valid && !mem_ready && !flush) |=> (res_valid && $stable(res)))
    else begin
      errors++;
      $display("%0d ns: held result changed or vanished before it was taken", $time);
    end

  a_latency: assert property (@(posedge CLK) disable iff (!nRST)
    (op_valid && op_ready && !flush) ##1 (op_ready && !flush) |=> res_valid)
    else begin
      errors++;
      $display("%0d ns: result not valid two cycles after accept", $time);
    end

  a_first_res: assert property (@(posedge CLK) disable iff (!nRST)
    res_valid |-> (acc_cycles >= 2))
    else begin
      errors++;
      $display("%0d ns: result valid too early after the first accept", $time);
    end

  a_apb_err: assert property (@(posedge CLK) disable iff (!nRST)
    (psel && penable) |-> (pslverr == apb_exp_err))
    else begin
      errors++;
      $display("[FAIL] %0d ns pslverr expected %b got %b", $time, $sampled(apb_exp_err),
               $sampled(pslverr));
    end

  a_apb_idle_err: assert property (@(posedge CLK) disable iff (!nRST)
    !(psel && penable) |-> !pslverr)
    else begin
      errors++;
      $display("[FAIL] %0d ns pslverr expected 0 got %b", $time, $sampled(pslverr));
    end

  a_apb_rdata: assert property (@(posedge CLK) disable iff (!nRST)
    (psel && penable && !pwrite) |-> (prdata == apb_exp_rd))
    else begin
      errors++;
      $display("[FAIL] %0d ns prdata expected %h got %h", $time, $sampled(apb_exp_rd),
               $sampled(prdata));
    end

  a_pready: assert property (@(posedge CLK) disable iff (!nRST) psel |-> pready)
    else begin
      errors++;
      $display("[FAIL] %0d ns pready expected 1 got %b", $time, $sampled(pready));
    end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("checks done, %0d errors", errors);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int s;
    nRST = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    op_valid = 1'b0;
    op = '0;
    mem_ready = 1'b1;
    flush = 1'b0;
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);

    // reset values, read back, bad vl and unmapped offsets
    apb_access(1'b0, `VEX_CFG_VL, 32'd0);
    apb_access(1'b0, `VEX_CFG_VTYPE, 32'd0);
    apb_access(1'b0, `VEX_CFG_STRIDE, 32'd0);
    write_read(`VEX_CFG_VL, 32'd17);
    write_read(`VEX_CFG_VTYPE, 32'd1);
    write_read(`VEX_CFG_STRIDE, 32'h0000_0104);
    write_read(`VEX_CFG_VL, 32'd40);
    write_read(`VEX_CFG_VL, 32'd32);
    write_read(8'h0c, 32'hdead_beef);
    write_read(8'h40, 32'd3);

    for (s = 0; s < 3; s++) begin
      apb_access(1'b1, `VEX_CFG_VTYPE, 32'(s));
      run_ops(N_ALU, 0, 1'b0);
      drain();
    end

    // reductions with one element and with several
    apb_access(1'b1, `VEX_CFG_VL, 32'd1);
    run_ops(N_RED, 0, 1'b1);
    drain();
    apb_access(1'b1, `VEX_CFG_VL, 32'd5);
    apb_access(1'b1, `VEX_CFG_VTYPE, 32'd0);
    run_ops(N_RED, 0, 1'b1);
    drain();

    write_read(`VEX_CFG_STRIDE, 32'h0000_0040);
    run_ops(N_MEM, 1, 1'b0);
    drain();
    write_read(`VEX_CFG_STRIDE, rand32());
    run_ops(N_MEM, 1, 1'b0);
    drain();

    // back to back with random back-pressure
    mem_mode = 1;
    run_ops(N_STREAM, 2, 1'b0);
    drain();

    // two ops stuck behind a stalled memory stage and then dropped
    mem_mode = 2;
    run_ops(2, 2, 1'b0);
    op_valid = 1'b0;
    mem_ready = 1'b0;
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    mem_mode = 0;
    mem_ready = 1'b1;
    repeat (4) @(negedge CLK);
    run_ops(N_AFTER_FLUSH, 2, 1'b0);
    drain();

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/vex_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module vex_addr_gen (
  input  wire [`VEX_XLEN-1:0]        base,
  input  wire vex_pkg::stride_e      stride_type,
  input  wire vex_pkg::sew_e         eew,
  input  wire [`VEX_NF_W-1:0]        nf,
  input  wire [`VEX_NF_W-1:0]        nf_count,
  input  wire [`VEX_XLEN-1:0]        cfg_stride,
  output logic [`VEX_XLEN-1:0]       addr0,
  output logic [`VEX_XLEN-1:0]       addr1
);

  logic [1:0]           size_shift;
  logic [`VEX_XLEN-1:0] field_off;
  logic [`VEX_XLEN-1:0] seg_stride;
  logic [`VEX_XLEN-1:0] lane_stride;

  // element size in bytes as a shift
  always_comb begin
    case (eew)
      vex_pkg::SEW8:  size_shift = 2'd0;
      vex_pkg::SEW16: size_shift = 2'd1;
      default:        size_shift = 2'd2;
    endcase
  end

  // offset of the current field inside a segment
  assign field_off  = `VEX_XLEN'(nf_count) << size_shift;
  assign seg_stride = (`VEX_XLEN'(nf) + `VEX_XLEN'(1)) << size_shift;

  always_comb begin
    case (stride_type)
      vex_pkg::STRIDE_STRIDED: lane_stride = cfg_stride;
      vex_pkg::STRIDE_SEGMENT: lane_stride = seg_stride;
      default:                 lane_stride = `VEX_XLEN'(4);
    endcase
  end

  assign addr0 = base + field_off;
  assign addr1 = addr0 + lane_stride;

endmodule

`default_nettype wire

// ==== design/vex_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module vex_cfg_regs (
  input  wire                        CLK,
  input  wire                        nRST,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [7:0]                  paddr,
  input  wire [`VEX_XLEN-1:0]        pwdata,
  output logic [`VEX_XLEN-1:0]       prdata,
  output logic                       pready,
  output logic                       pslverr,
  output vex_pkg::vex_cfg_t          cfg
);

  logic access;
  logic hit_vl;
  logic hit_vtype;
  logic hit_stride;
  logic vl_bad;
  logic wr_ok;

  // access phase of a transfer
  assign access     = psel & penable;
  assign hit_vl     = paddr == `VEX_CFG_VL;
  assign hit_vtype  = paddr == `VEX_CFG_VTYPE;
  assign hit_stride = paddr == `VEX_CFG_STRIDE;
  assign vl_bad     = pwrite & hit_vl & (pwdata > `VEX_VLMAX);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access & (~(hit_vl | hit_vtype | hit_stride) | vl_bad);
  assign wr_ok   = access & pwrite & ~pslverr;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg.vl     <= `VEX_VL_W'(`VEX_RST_VL);
      cfg.sew    <= vex_pkg::SEW32;
      cfg.stride <= `VEX_XLEN'(`VEX_RST_STRIDE);
    end else if (wr_ok) begin
      if (hit_vl) cfg.vl <= pwdata[`VEX_VL_W-1:0];
      if (hit_vtype) cfg.sew <= vex_pkg::sew_e'(pwdata[1:0]);
      if (hit_stride) cfg.stride <= pwdata;
    end
  end

  // read back, unmapped reads as zero
  always_comb begin
    prdata = '0;
    if (hit_vl) begin
      prdata[`VEX_VL_W-1:0] = cfg.vl;
    end else if (hit_vtype) begin
      prdata[1:0] = cfg.sew;
    end else if (hit_stride) begin
      prdata = cfg.stride;
    end
  end

  a_penable_needs_psel: assert property (@(posedge CLK) disable iff (!nRST)
    penable |-> psel);

endmodule

`default_nettype wire

// ==== design/vex_consts.svh ====
`ifndef VEX_CONSTS_SVH
`define VEX_CONSTS_SVH

// datapath width, shared by lanes, address path and APB data
`define VEX_XLEN 32

// vector register number
`define VEX_VREG_W 5

// vector length field, wide enough to hold VEX_VLMAX
`define VEX_VL_W 6

// largest vl accepted by the config block
`define VEX_VLMAX 32

// APB byte offsets of the config registers
`define VEX_CFG_VL     8'h00
`define VEX_CFG_VTYPE  8'h04
`define VEX_CFG_STRIDE 8'h08

// values loaded on reset
`define VEX_RST_VL     0
`define VEX_RST_STRIDE 4

// segment field count, nf and nf_count
`define VEX_NF_W 3

`endif

// ==== design/vex_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module vex_execute (
  input  wire                        CLK,
  input  wire                        nRST,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [7:0]                  paddr,
  input  wire [`VEX_XLEN-1:0]        pwdata,
  output logic [`VEX_XLEN-1:0]       prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  wire                        op_valid,
  input  wire vex_pkg::vex_op_t      op,
  output logic                       op_ready,
  output logic                       res_valid,
  output vex_pkg::vex_res_t          res,
  input  wire                        mem_ready,
  input  wire                        flush
);

  vex_pkg::vex_cfg_t    cfg;
  logic                 iss_valid;
  vex_pkg::vex_op_t     iss_op;
  logic [`VEX_XLEN-1:0] lane0_res;
  logic [`VEX_XLEN-1:0] lane1_res;
  logic [`VEX_XLEN-1:0] addr0;
  logic [`VEX_XLEN-1:0] addr1;
  vex_pkg::vex_res_t    ex_res;

  // one enable for both stages, stalls while a result waits
  assign op_ready = mem_ready | ~res_valid;

  vex_cfg_regs u_cfg_regs (.CLK, .nRST, .psel, .penable, .pwrite, .paddr, .pwdata,
                           .prdata, .pready, .pslverr, .cfg);

  vex_stage_reg #(.payload_t(vex_pkg::vex_op_t)) u_issue (
    .CLK, .nRST, .en(op_ready), .flush, .in_valid(op_valid), .in_data(op),
    .out_valid(iss_valid), .out_data(iss_op));

  vex_lane_alu u_lane0 (.src1(iss_op.src1), .src2(iss_op.src2), .vs1(iss_op.vs1_lane0),
                        .vs2(iss_op.vs2_lane0), .imm(iss_op.imm), .xs(iss_op.xs1),
                        .alu_op(iss_op.alu_op), .sew(cfg.sew), .result(lane0_res));

  vex_lane_alu u_lane1 (.src1(iss_op.src1), .src2(iss_op.src2), .vs1(iss_op.vs1_lane1),
                        .vs2(iss_op.vs2_lane1), .imm(iss_op.imm), .xs(iss_op.xs1),
                        .alu_op(iss_op.alu_op), .sew(cfg.sew), .result(lane1_res));

  // base address from the second scalar operand
  vex_addr_gen u_addr_gen (.base(iss_op.xs2), .stride_type(iss_op.stride_type),
                           .eew(iss_op.eew), .nf(iss_op.nf), .nf_count(iss_op.nf_count),
                           .cfg_stride(cfg.stride), .addr0, .addr1);

  vex_reduce u_reduce (.fu(iss_op.fu), .reduce(iss_op.reduce), .alu_op(iss_op.alu_op),
                       .sew(cfg.sew), .vl(cfg.vl), .lane0(lane0_res), .lane1(lane1_res),
                       .addr0, .addr1, .result0(ex_res.result0), .result1(ex_res.result1));

  assign ex_res.fu     = iss_op.fu;
  assign ex_res.vd     = iss_op.vd;
  assign ex_res.wen    = iss_op.wen;
  assign ex_res.store0 = iss_op.store0;
  assign ex_res.store1 = iss_op.store1;

  vex_stage_reg #(.payload_t(vex_pkg::vex_res_t)) u_retire (
    .CLK, .nRST, .en(op_ready), .flush, .in_valid(iss_valid), .in_data(ex_res),
    .out_valid(res_valid), .out_data(res));

endmodule

`default_nettype wire

// ==== design/vex_lane_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module vex_lane_alu (
  input  wire vex_pkg::src_e         src1,
  input  wire vex_pkg::src_e         src2,
  input  wire [`VEX_XLEN-1:0]        vs1,
  input  wire [`VEX_XLEN-1:0]        vs2,
  input  wire [`VEX_XLEN-1:0]        imm,
  input  wire [`VEX_XLEN-1:0]        xs,
  input  wire vex_pkg::alu_op_e      alu_op,
  input  wire vex_pkg::sew_e         sew,
  output logic [`VEX_XLEN-1:0]       result
);

  logic [`VEX_XLEN-1:0] opa;
  logic [`VEX_XLEN-1:0] opb;

  // vector, immediate or scalar operand
  function automatic logic [`VEX_XLEN-1:0] operand_sel(input vex_pkg::src_e src,
                                                       input logic [`VEX_XLEN-1:0] v,
                                                       input logic [`VEX_XLEN-1:0] i,
                                                       input logic [`VEX_XLEN-1:0] x);
    case (src)
      vex_pkg::SRC_V: operand_sel = v;
      vex_pkg::SRC_I: operand_sel = i;
      vex_pkg::SRC_X: operand_sel = x;
      default:        operand_sel = '0;
    endcase
  endfunction

  assign opa = operand_sel(src1, vs1, imm, xs);
  assign opb = operand_sel(src2, vs2, imm, xs);

  // signed min/max compare at sew, unsigned at full width
  assign result = vex_pkg::alu_eval(alu_op, opa, opb, sew);

endmodule

`default_nettype wire

// ==== design/vex_pkg.sv ====
`default_nettype none
`include "vex_consts.svh"

package vex_pkg;

  typedef enum logic [1:0] {SRC_V, SRC_I, SRC_X} src_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU
  } alu_op_e;

  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_e;

  typedef enum logic [1:0] {STRIDE_UNIT, STRIDE_STRIDED, STRIDE_SEGMENT} stride_e;

  typedef enum logic [1:0] {FU_ALU, FU_LOAD, FU_STORE} fu_e;

  // one decoded op, both lanes
  typedef struct packed {
    fu_e                     fu;
    alu_op_e                 alu_op;
    src_e                    src1;
    src_e                    src2;
    logic                    reduce;
    sew_e                    eew;
    stride_e                 stride_type;
    logic [`VEX_NF_W-1:0]    nf;
    logic [`VEX_NF_W-1:0]    nf_count;
    logic [`VEX_VREG_W-1:0]  vd;
    logic [1:0]              wen;
    logic [`VEX_XLEN-1:0]    imm;
    logic [`VEX_XLEN-1:0]    xs1;
    logic [`VEX_XLEN-1:0]    xs2;
    logic [`VEX_XLEN-1:0]    vs1_lane0;
    logic [`VEX_XLEN-1:0]    vs1_lane1;
    logic [`VEX_XLEN-1:0]    vs2_lane0;
    logic [`VEX_XLEN-1:0]    vs2_lane1;
    logic [`VEX_XLEN-1:0]    store0;
    logic [`VEX_XLEN-1:0]    store1;
  } vex_op_t;

  typedef struct packed {
    logic [`VEX_VL_W-1:0]  vl;
    sew_e                  sew;
    logic [`VEX_XLEN-1:0]  stride;
  } vex_cfg_t;

  // what leaves for the memory stage
  typedef struct packed {
    fu_e                     fu;
    logic [`VEX_VREG_W-1:0]  vd;
    logic [1:0]              wen;
    logic [`VEX_XLEN-1:0]    result0;
    logic [`VEX_XLEN-1:0]    result1;
    logic [`VEX_XLEN-1:0]    store0;
    logic [`VEX_XLEN-1:0]    store1;
  } vex_res_t;

  // sign extend the low sew bits to full width
  function automatic logic [`VEX_XLEN-1:0] sew_sext(input logic [`VEX_XLEN-1:0] v,
                                                    input sew_e sew);
    case (sew)
      SEW8:    sew_sext = {{(`VEX_XLEN-8){v[7]}}, v[7:0]};
      SEW16:   sew_sext = {{(`VEX_XLEN-16){v[15]}}, v[15:0]};
      default: sew_sext = v;
    endcase
  endfunction

  // integer op shared by the lanes and the reduction combine
  function automatic logic [`VEX_XLEN-1:0] alu_eval(input alu_op_e op,
                                                    input logic [`VEX_XLEN-1:0] a,
                                                    input logic [`VEX_XLEN-1:0] b,
                                                    input sew_e sew);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(sew_sext(a, sew)) < $signed(sew_sext(b, sew));
    lt_u = a < b;
    case (op)
      ALU_ADD:  alu_eval = a + b;
      ALU_AND:  alu_eval = a & b;
      ALU_OR:   alu_eval = a | b;
      ALU_XOR:  alu_eval = a ^ b;
      ALU_MIN:  alu_eval = lt_s ? a : b;
      ALU_MINU: alu_eval = lt_u ? a : b;
      ALU_MAX:  alu_eval = lt_s ? b : a;
      ALU_MAXU: alu_eval = lt_u ? b : a;
      default:  alu_eval = '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/vex_reduce.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vex_consts.svh"

module vex_reduce (
  input  wire vex_pkg::fu_e          fu,
  input  wire                        reduce,
  input  wire vex_pkg::alu_op_e      alu_op,
  input  wire vex_pkg::sew_e         sew,
  input  wire [`VEX_VL_W-1:0]        vl,
  input  wire [`VEX_XLEN-1:0]        lane0,
  input  wire [`VEX_XLEN-1:0]        lane1,
  input  wire [`VEX_XLEN-1:0]        addr0,
  input  wire [`VEX_XLEN-1:0]        addr1,
  output logic [`VEX_XLEN-1:0]       result0,
  output logic [`VEX_XLEN-1:0]       result1
);

  logic                 is_mem;
  logic                 do_combine;
  logic [`VEX_XLEN-1:0] combined;

  assign is_mem = (fu == vex_pkg::FU_LOAD) | (fu == vex_pkg::FU_STORE);

  // a single element has nothing to fold in
  assign do_combine = reduce & (vl != `VEX_VL_W'(1));

  // same op and sew rule as the lanes
  assign combined = vex_pkg::alu_eval(alu_op, lane0, lane1, sew);

  always_comb begin
    if (is_mem) begin
      result0 = addr0;
      result1 = addr1;
    end else if (do_combine) begin
      result0 = combined;
      result1 = lane1;
    end else begin
      result0 = lane0;
      result1 = lane1;
    end
  end

endmodule

`default_nettype wire

// ==== design/vex_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module vex_stage_reg #(
  parameter type payload_t = logic
) (
  input  wire       CLK,
  input  wire       nRST,
  input  wire       en,
  input  wire       flush,
  input  wire       in_valid,
  input  wire       payload_t in_data,
  output logic      out_valid,
  output payload_t  out_data
);

  // flush wins over enable
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (en) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (en) out_data <= in_data;
  end

  // a valid word never carries unknown bits
  a_valid_data_known: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid |-> !$isunknown(out_data));

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/vex_pkg.sv
design/vex_cfg_regs.sv
design/vex_stage_reg.sv
design/vex_lane_alu.sv
design/vex_addr_gen.sv
design/vex_reduce.sv
design/vex_execute.sv
bench/tb_vex_execute.sv
